//--- rv_core_pkg.sv
package rv_core_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;

  // first fetch address after reset
  localparam xlen_t RESET_PC = 32'h8000_0000;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  localparam logic [2:0] F3_ADDI     = 3'b000;
  localparam logic [2:0] F3_WORD     = 3'b010;
  localparam xlen_t      EBREAK_WORD = 32'h0010_0073;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef enum logic [3:0] {
    K_ADDI,
    K_LUI,
    K_AUIPC,
    K_JAL,
    K_JALR,
    K_LW,
    K_SW,
    K_EBREAK,
    K_ILLEGAL
  } inst_kind_e;

  typedef enum logic [2:0] {
    FETCH_REQ,
    FETCH_WAIT,
    EXEC,
    LOAD_REQ,
    LOAD_WAIT,
    STORE_REQ,
    STORE_RESP,
    HALT
  } fsm_state_e;

  // I type, also used for opcode, funct3, rd and rs1 of every format
  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // jal offset is scattered across the upper bits
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

endpackage

//--- core_fsm.sv
module core_fsm (
  input  logic                    clk,
  input  logic                    arst_n,
  input  rv_core_pkg::inst_kind_e inst_kind,
  input  rv_core_pkg::xlen_t      pc,
  input  rv_core_pkg::xlen_t      mem_addr,
  input  rv_core_pkg::xlen_t      store_data,
  output rv_core_pkg::xlen_t      araddr,
  output logic                    arvalid,
  input  logic                    arready,
  input  logic                    rvalid,
  input  logic [1:0]              rresp,
  output logic                    rready,
  output rv_core_pkg::xlen_t      awaddr,
  output logic                    awvalid,
  input  logic                    awready,
  output rv_core_pkg::xlen_t      wdata,
  output logic                    wvalid,
  input  logic                    wready,
  input  logic                    bvalid,
  input  logic [1:0]              bresp,
  output logic                    bready,
  output logic                    ir_load,
  output logic                    reg_we,
  output logic                    pc_step,
  output logic                    halted,
  output logic                    error
);

  rv_core_pkg::fsm_state_e state;
  logic r_done;
  logic r_okay;
  logic b_done;
  logic b_okay;
  logic simple_op;

  assign r_done = rvalid && rready;
  assign r_okay = (rresp == rv_core_pkg::RESP_OKAY);
  assign b_done = bvalid && bready;
  assign b_okay = (bresp == rv_core_pkg::RESP_OKAY);

  // instructions that retire in EXEC without a bus access
  assign simple_op = !((inst_kind == rv_core_pkg::K_LW) || (inst_kind == rv_core_pkg::K_SW) ||
                       (inst_kind == rv_core_pkg::K_EBREAK) ||
                       (inst_kind == rv_core_pkg::K_ILLEGAL));

  // address lines only change when the pc or the operands change
  assign araddr = (state == rv_core_pkg::LOAD_REQ) ? mem_addr : pc;
  assign awaddr = mem_addr;
  assign wdata  = store_data;
  assign halted = (state == rv_core_pkg::HALT);

  // one-cycle strobes
  assign ir_load = (state == rv_core_pkg::FETCH_WAIT) && r_done;
  assign reg_we  = ((state == rv_core_pkg::EXEC) && simple_op) ||
                   ((state == rv_core_pkg::LOAD_WAIT) && r_done && r_okay);
  assign pc_step = reg_we || ((state == rv_core_pkg::STORE_RESP) && b_done && b_okay);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= rv_core_pkg::FETCH_REQ;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      error   <= 1'b0;
    end else begin
      case (state)
        rv_core_pkg::FETCH_REQ, rv_core_pkg::LOAD_REQ: begin
          // arvalid rises here on the first cycle out of reset
          arvalid <= 1'b1;
          if (arvalid && arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= (state == rv_core_pkg::FETCH_REQ) ? rv_core_pkg::FETCH_WAIT
                                                         : rv_core_pkg::LOAD_WAIT;
          end
        end
        rv_core_pkg::FETCH_WAIT, rv_core_pkg::LOAD_WAIT: begin
          if (r_done) begin
            rready <= 1'b0;
            if (!r_okay) begin
              error <= 1'b1;
              state <= rv_core_pkg::HALT;
            end else if (state == rv_core_pkg::FETCH_WAIT) begin
              state <= rv_core_pkg::EXEC;
            end else begin
              arvalid <= 1'b1;
              state   <= rv_core_pkg::FETCH_REQ;
            end
          end
        end
        rv_core_pkg::EXEC: begin
          case (inst_kind)
            rv_core_pkg::K_LW: begin
              arvalid <= 1'b1;
              state   <= rv_core_pkg::LOAD_REQ;
            end
            rv_core_pkg::K_SW: begin
              awvalid <= 1'b1;
              wvalid  <= 1'b1;
              state   <= rv_core_pkg::STORE_REQ;
            end
            rv_core_pkg::K_EBREAK: state <= rv_core_pkg::HALT;
            rv_core_pkg::K_ILLEGAL: begin
              error <= 1'b1;
              state <= rv_core_pkg::HALT;
            end
            default: begin
              arvalid <= 1'b1;
              state   <= rv_core_pkg::FETCH_REQ;
            end
          endcase
        end
        rv_core_pkg::STORE_REQ: begin
          // address and data may complete on different cycles
          if (awvalid && awready) begin
            awvalid <= 1'b0;
          end
          if (wvalid && wready) begin
            wvalid <= 1'b0;
          end
          if ((!awvalid || awready) && (!wvalid || wready)) begin
            bready <= 1'b1;
            state  <= rv_core_pkg::STORE_RESP;
          end
        end
        rv_core_pkg::STORE_RESP: begin
          if (b_done) begin
            bready <= 1'b0;
            if (b_okay) begin
              arvalid <= 1'b1;
              state   <= rv_core_pkg::FETCH_REQ;
            end else begin
              error <= 1'b1;
              state <= rv_core_pkg::HALT;
            end
          end
        end
        rv_core_pkg::HALT: state <= rv_core_pkg::HALT;
      endcase
    end
  end

endmodule

//--- pc_counter.sv
module pc_counter (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               pc_step,
  input  rv_core_pkg::xlen_t next_pc,
  output rv_core_pkg::xlen_t pc
);

  // next_pc already holds either pc + 4 or the jump target
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= rv_core_pkg::RESET_PC;
    end else if (pc_step) begin
      pc <= next_pc;
    end
  end

endmodule

//--- inst_decoder.sv
module inst_decoder (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    ir_load,
  input  rv_core_pkg::xlen_t      rdata,
  output rv_core_pkg::inst_kind_e inst_kind,
  output rv_core_pkg::reg_addr_t  rs1,
  output rv_core_pkg::reg_addr_t  rs2,
  output rv_core_pkg::reg_addr_t  rd,
  output rv_core_pkg::xlen_t      imm
);

  rv_core_pkg::inst_u ir;
  logic [6:0] opcode;
  logic [2:0] funct3;

  // instruction register, loaded on the fetch data transfer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ir <= '0;
    end else if (ir_load) begin
      ir <= rdata;
    end
  end

  // these fields sit at the same bits in every format
  assign opcode = ir.i_fmt.opcode;
  assign funct3 = ir.i_fmt.funct3;
  assign rs1    = ir.i_fmt.rs1;
  assign rd     = ir.i_fmt.rd;
  assign rs2    = ir.s_fmt.rs2;

  always_comb begin
    inst_kind = rv_core_pkg::K_ILLEGAL;
    case (opcode)
      rv_core_pkg::OPC_OP_IMM: begin
        if (funct3 == rv_core_pkg::F3_ADDI) inst_kind = rv_core_pkg::K_ADDI;
      end
      rv_core_pkg::OPC_LUI:   inst_kind = rv_core_pkg::K_LUI;
      rv_core_pkg::OPC_AUIPC: inst_kind = rv_core_pkg::K_AUIPC;
      rv_core_pkg::OPC_JAL:   inst_kind = rv_core_pkg::K_JAL;
      rv_core_pkg::OPC_JALR: begin
        // jalr only defines funct3 of zero
        if (funct3 == 3'b000) inst_kind = rv_core_pkg::K_JALR;
      end
      rv_core_pkg::OPC_LOAD: begin
        if (funct3 == rv_core_pkg::F3_WORD) inst_kind = rv_core_pkg::K_LW;
      end
      rv_core_pkg::OPC_STORE: begin
        if (funct3 == rv_core_pkg::F3_WORD) inst_kind = rv_core_pkg::K_SW;
      end
      rv_core_pkg::OPC_SYSTEM: begin
        if (ir == rv_core_pkg::EBREAK_WORD) inst_kind = rv_core_pkg::K_EBREAK;
      end
      default: inst_kind = rv_core_pkg::K_ILLEGAL;
    endcase
  end

  // sign-extended immediate per format
  always_comb begin
    case (inst_kind)
      rv_core_pkg::K_SW:
        imm = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
      rv_core_pkg::K_LUI, rv_core_pkg::K_AUIPC:
        imm = {ir.u_fmt.imm, 12'h000};
      rv_core_pkg::K_JAL:
        imm = {{11{ir.j_fmt.imm20}}, ir.j_fmt.imm20, ir.j_fmt.imm19_12,
               ir.j_fmt.imm11, ir.j_fmt.imm10_1, 1'b0};
      default:
        imm = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
    endcase
  end

endmodule

//--- reg_file.sv
module reg_file (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   we,
  input  rv_core_pkg::reg_addr_t waddr,
  input  rv_core_pkg::xlen_t     wdata,
  input  rv_core_pkg::reg_addr_t rs1,
  input  rv_core_pkg::reg_addr_t rs2,
  output rv_core_pkg::xlen_t     rs1_data,
  output rv_core_pkg::xlen_t     rs2_data
);

  // x1 to x31, x0 has no storage
  rv_core_pkg::xlen_t regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- exec_unit.sv
module exec_unit (
  input  rv_core_pkg::inst_kind_e inst_kind,
  input  rv_core_pkg::xlen_t      pc,
  input  rv_core_pkg::xlen_t      imm,
  input  rv_core_pkg::xlen_t      rs1_data,
  input  rv_core_pkg::xlen_t      rs2_data,
  input  rv_core_pkg::xlen_t      load_data,
  output rv_core_pkg::xlen_t      mem_addr,
  output rv_core_pkg::xlen_t      store_data,
  output rv_core_pkg::xlen_t      next_pc,
  output rv_core_pkg::xlen_t      wb_data
);

  rv_core_pkg::xlen_t op_a;
  rv_core_pkg::xlen_t sum;
  rv_core_pkg::xlen_t pc_plus4;

  // first adder operand
  always_comb begin
    case (inst_kind)
      rv_core_pkg::K_AUIPC, rv_core_pkg::K_JAL: op_a = pc;
      rv_core_pkg::K_LUI:                       op_a = '0;
      default:                                  op_a = rs1_data;
    endcase
  end

  assign sum        = op_a + imm;
  assign pc_plus4   = pc + 32'd4;
  assign mem_addr   = sum;
  assign store_data = rs2_data;

  always_comb begin
    case (inst_kind)
      rv_core_pkg::K_JAL:  next_pc = sum;
      // jalr target drops bit 0
      rv_core_pkg::K_JALR: next_pc = {sum[31:1], 1'b0};
      default:             next_pc = pc_plus4;
    endcase
  end

  always_comb begin
    case (inst_kind)
      rv_core_pkg::K_JAL, rv_core_pkg::K_JALR: wb_data = pc_plus4;
      rv_core_pkg::K_LW:                       wb_data = load_data;
      default:                                 wb_data = sum;
    endcase
  end

endmodule

//--- rv_core_top.sv
module rv_core_top (
  input  logic               clk,
  input  logic               arst_n,
  output rv_core_pkg::xlen_t araddr,
  output logic               arvalid,
  input  logic               arready,
  input  rv_core_pkg::xlen_t rdata,
  input  logic [1:0]         rresp,
  input  logic               rvalid,
  output logic               rready,
  output rv_core_pkg::xlen_t awaddr,
  output logic               awvalid,
  input  logic               awready,
  output rv_core_pkg::xlen_t wdata,
  output logic               wvalid,
  input  logic               wready,
  input  logic [1:0]         bresp,
  input  logic               bvalid,
  output logic               bready,
  output logic               halted,
  output logic               error
);

  rv_core_pkg::inst_kind_e inst_kind;
  rv_core_pkg::xlen_t      pc;
  rv_core_pkg::xlen_t      next_pc;
  rv_core_pkg::xlen_t      imm;
  rv_core_pkg::xlen_t      rs1_data;
  rv_core_pkg::xlen_t      rs2_data;
  rv_core_pkg::xlen_t      mem_addr;
  rv_core_pkg::xlen_t      store_data;
  rv_core_pkg::xlen_t      wb_data;
  rv_core_pkg::reg_addr_t  rs1;
  rv_core_pkg::reg_addr_t  rs2;
  rv_core_pkg::reg_addr_t  rd;
  logic                    ir_load;
  logic                    reg_we;
  logic                    pc_step;

  core_fsm core_fsm_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_kind  (inst_kind),
    .pc         (pc),
    .mem_addr   (mem_addr),
    .store_data (store_data),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rvalid     (rvalid),
    .rresp      (rresp),
    .rready     (rready),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bresp      (bresp),
    .bready     (bready),
    .ir_load    (ir_load),
    .reg_we     (reg_we),
    .pc_step    (pc_step),
    .halted     (halted),
    .error      (error)
  );

  pc_counter pc_counter_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .pc_step (pc_step),
    .next_pc (next_pc),
    .pc      (pc)
  );

  // read data serves both the instruction fetch and lw
  inst_decoder inst_decoder_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .ir_load   (ir_load),
    .rdata     (rdata),
    .inst_kind (inst_kind),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .we       (reg_we),
    .waddr    (rd),
    .wdata    (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exec_unit exec_unit_inst (
    .inst_kind  (inst_kind),
    .pc         (pc),
    .imm        (imm),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .load_data  (rdata),
    .mem_addr   (mem_addr),
    .store_data (store_data),
    .next_pc    (next_pc),
    .wb_data    (wb_data)
  );

endmodule

//--- tb_rv_core.sv
module tb_rv_core;

  logic               clk;
  logic               arst_n;
  rv_core_pkg::xlen_t araddr;
  logic               arvalid;
  logic               arready;
  rv_core_pkg::xlen_t rdata;
  logic [1:0]         rresp;
  logic               rvalid;
  logic               rready;
  rv_core_pkg::xlen_t awaddr;
  logic               awvalid;
  logic               awready;
  rv_core_pkg::xlen_t wdata;
  logic               wvalid;
  logic               wready;
  logic [1:0]         bresp;
  logic               bvalid;
  logic               bready;
  logic               halted;
  logic               error;

  // 4 KiB window at the reset vector with the fill pattern elsewhere
  rv_core_pkg::xlen_t mem [0:1023];
  rv_core_pkg::xlen_t ref_mem [0:1023];
  rv_core_pkg::xlen_t exp_read [$];
  rv_core_pkg::xlen_t exp_st_addr [$];
  rv_core_pkg::xlen_t exp_st_data [$];
  int n_checks;
  int n_errors;
  int bad_read;
  int read_idx;
  int ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
  logic r_pend, aw_done, w_done;
  rv_core_pkg::xlen_t s_araddr, s_awaddr, s_wdata;
  rv_core_pkg::xlen_t mon_awaddr, mon_wdata;
  logic held_ar, held_aw, held_w;
  rv_core_pkg::xlen_t held_araddr, held_awaddr, held_wdata;
  time wd_limit;
  logic wd_armed;

  rv_core_top rv_core_top_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .halted  (halted),
    .error   (error)
  );

  always #20 clk = ~clk;

  function automatic rv_core_pkg::xlen_t fill(input rv_core_pkg::xlen_t addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
  endfunction

  function automatic rv_core_pkg::xlen_t ref_read(input rv_core_pkg::xlen_t addr);
    if (addr[31:12] == 20'h80000) return ref_mem[addr[11:2]];
    return fill(addr);
  endfunction

  function automatic rv_core_pkg::xlen_t enc_i(input logic [11:0] imm, input int rs1,
                                               input logic [2:0] f3, input int rd,
                                               input logic [6:0] opc);
    return {imm, rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic rv_core_pkg::xlen_t enc_u(input logic [19:0] imm, input int rd,
                                               input logic [6:0] opc);
    return {imm, rd[4:0], opc};
  endfunction

  function automatic rv_core_pkg::xlen_t enc_sw(input logic [11:0] imm, input int rs2,
                                                input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic rv_core_pkg::xlen_t enc_j(input logic [20:0] off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
  endfunction

  // ISA model that fills the expected queues and returns {error, halted}
  function automatic logic [1:0] run_model(input int bad);
    rv_core_pkg::xlen_t x [32];
    rv_core_pkg::xlen_t pc, w, a, t, immi, imms;
    int nread;
    int rd;
    pc = rv_core_pkg::RESET_PC;
    nread = 0;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int step = 0; step < 1000; step++) begin
      exp_read.push_back(pc);
      if (nread == bad) return 2'b11;
      nread++;
      w = ref_read(pc);
      rd = w[11:7];
      immi = {{20{w[31]}}, w[31:20]};
      imms = {{20{w[31]}}, w[31:25], w[11:7]};
      if (w == 32'h0010_0073) return 2'b01;
      if (w[6:0] == 7'h13 && w[14:12] == 3'b000) begin
        t = x[w[19:15]] + immi;
        pc = pc + 4;
      end else if (w[6:0] == 7'h37) begin
        t = {w[31:12], 12'h000};
        pc = pc + 4;
      end else if (w[6:0] == 7'h17) begin
        t = pc + {w[31:12], 12'h000};
        pc = pc + 4;
      end else if (w[6:0] == 7'h6f) begin
        t = pc + 4;
        pc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end else if (w[6:0] == 7'h67 && w[14:12] == 3'b000) begin
        a = (x[w[19:15]] + immi) & ~32'd1;
        t = pc + 4;
        pc = a;
      end else if (w[6:0] == 7'h03 && w[14:12] == 3'b010) begin
        a = x[w[19:15]] + immi;
        exp_read.push_back(a);
        if (nread == bad) return 2'b11;
        nread++;
        t = ref_read(a);
        pc = pc + 4;
      end else if (w[6:0] == 7'h23 && w[14:12] == 3'b010) begin
        a = x[w[19:15]] + imms;
        exp_st_addr.push_back(a);
        exp_st_data.push_back(x[w[24:20]]);
        if (a[31:12] == 20'h80000) ref_mem[a[11:2]] = x[w[24:20]];
        rd = 0;
        pc = pc + 4;
      end else begin
        return 2'b11;
      end
      if (rd != 0) x[rd] = t;
    end
    return 2'b00;
  endfunction

  task automatic clear_mem();
    for (int i = 0; i < 1024; i++) mem[i] = fill(32'h8000_0000 + 4 * i);
  endtask

  // stores, a load back, a jal and a jalr with an odd target
  task automatic load_main_program();
    clear_mem();
    mem[0]  = {20'h80001, 5'd5, 7'h37};
    mem[1]  = enc_i(12'h800, 5, 3'b000, 5, 7'h13);
    mem[2]  = enc_i($urandom, 0, 3'b000, 1, 7'h13);
    mem[3]  = enc_i($urandom, 1, 3'b000, 2, 7'h13);
    mem[4]  = enc_u($urandom, 3, 7'h17);
    mem[5]  = enc_u($urandom, 7, 7'h37);
    mem[6]  = enc_sw(0, 1, 5);
    mem[7]  = enc_sw(4, 2, 5);
    mem[8]  = enc_sw(8, 3, 5);
    mem[9]  = enc_sw(12, 7, 5);
    mem[10] = enc_i(4, 5, 3'b010, 4, 7'h03);
    mem[11] = enc_i(1, 4, 3'b000, 4, 7'h13);
    mem[12] = enc_sw(16, 4, 5);
    mem[13] = enc_j(21'd8, 6);
    mem[14] = 32'h0000_0000;
    mem[15] = enc_sw(20, 6, 5);
    mem[16] = {20'h00000, 5'd8, 7'h17};
    mem[17] = enc_i(17, 8, 3'b000, 8, 7'h13);
    mem[18] = enc_i(0, 8, 3'b000, 9, 7'h67);
    mem[19] = 32'h0000_0000;
    mem[20] = enc_sw(24, 9, 5);
    mem[21] = enc_sw(28, 8, 5);
    mem[22] = enc_i(16, 5, 3'b010, 10, 7'h03);
    mem[23] = enc_sw(32, 10, 5);
    mem[24] = 32'h0010_0073;
  endtask

  task automatic load_illegal_program();
    clear_mem();
    mem[0] = enc_i(5, 0, 3'b000, 1, 7'h13);
    mem[1] = {20'h80001, 5'd5, 7'h37};
    mem[2] = enc_i(12'h800, 5, 3'b000, 5, 7'h13);
    mem[3] = enc_sw(0, 1, 5);
    mem[4] = 32'hffff_ffff;
    mem[5] = 32'h0010_0073;
  endtask

  task automatic check_fetch(input rv_core_pkg::xlen_t got, input rv_core_pkg::xlen_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED araddr got %h expected %h", got, exp);
    end
  endtask

  task automatic check_store(input rv_core_pkg::xlen_t got_addr,
                             input rv_core_pkg::xlen_t got_data,
                             input rv_core_pkg::xlen_t exp_addr,
                             input rv_core_pkg::xlen_t exp_data);
    n_checks++;
    if (got_addr !== exp_addr) begin
      n_errors++;
      $display("CHECK FAILED awaddr got %h expected %h", got_addr, exp_addr);
    end
    if (got_data !== exp_data) begin
      n_errors++;
      $display("CHECK FAILED wdata got %h expected %h", got_data, exp_data);
    end
  endtask

  task automatic check_status(input logic got_h, input logic got_e,
                              input logic exp_h, input logic exp_e);
    n_checks++;
    if (got_h !== exp_h) begin
      n_errors++;
      $display("CHECK FAILED halted got %h expected %h", got_h, exp_h);
    end
    if (got_e !== exp_e) begin
      n_errors++;
      $display("CHECK FAILED error got %h expected %h", got_e, exp_e);
    end
  endtask

  task automatic run_test(input int bad);
    logic [1:0] end_state;
    @(posedge clk);
    arst_n <= 1'b0;
    bad_read = bad;
    exp_read.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
    for (int i = 0; i < 1024; i++) ref_mem[i] = mem[i];
    end_state = run_model(bad);
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    while (halted !== 1'b1) @(posedge clk);
    // idle window to catch any late valid
    repeat (10) @(posedge clk);
    check_status(halted, error, end_state[0], end_state[1]);
    if (exp_read.size() != 0 || exp_st_addr.size() != 0) begin
      n_errors++;
      $display("core halted with %0d reads and %0d stores still expected",
               exp_read.size(), exp_st_addr.size());
    end
  endtask

  // AXI4-Lite slave with random ready and valid delays
  always @(posedge clk) begin
    if (!arst_n) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      r_pend   <= 1'b0;
      aw_done  <= 1'b0;
      w_done   <= 1'b0;
      read_idx <= 0;
      ar_cnt   <= $urandom % 5;
      r_cnt    <= $urandom % 5;
      aw_cnt   <= $urandom % 5;
      w_cnt    <= $urandom % 5;
      b_cnt    <= $urandom % 5;
    end else begin
      arready <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      if (arvalid && !arready) begin
        if (ar_cnt == 0) arready <= 1'b1;
        else ar_cnt <= ar_cnt - 1;
      end
      if (arvalid && arready) begin
        s_araddr <= araddr;
        r_pend   <= 1'b1;
        ar_cnt   <= $urandom % 5;
      end
      if (r_pend && !rvalid) begin
        if (r_cnt == 0) begin
          rvalid <= 1'b1;
          rdata  <= (s_araddr[31:12] == 20'h80000) ? mem[s_araddr[11:2]] : fill(s_araddr);
          rresp  <= (read_idx == bad_read) ? 2'b10 : 2'b00;
        end else begin
          r_cnt <= r_cnt - 1;
        end
      end
      if (rvalid && rready) begin
        rvalid   <= 1'b0;
        r_pend   <= 1'b0;
        r_cnt    <= $urandom % 5;
        read_idx <= read_idx + 1;
      end
      if (awvalid && !awready && !aw_done) begin
        if (aw_cnt == 0) awready <= 1'b1;
        else aw_cnt <= aw_cnt - 1;
      end
      if (awvalid && awready) begin
        s_awaddr <= awaddr;
        aw_done  <= 1'b1;
        aw_cnt   <= $urandom % 5;
      end
      if (wvalid && !wready && !w_done) begin
        if (w_cnt == 0) wready <= 1'b1;
        else w_cnt <= w_cnt - 1;
      end
      if (wvalid && wready) begin
        s_wdata <= wdata;
        w_done  <= 1'b1;
        w_cnt   <= $urandom % 5;
      end
      if (aw_done && w_done && !bvalid) begin
        if (b_cnt == 0) bvalid <= 1'b1;
        else b_cnt <= b_cnt - 1;
      end
      if (bvalid && bready) begin
        bvalid  <= 1'b0;
        aw_done <= 1'b0;
        w_done  <= 1'b0;
        b_cnt   <= $urandom % 5;
        if (s_awaddr[31:12] == 20'h80000) mem[s_awaddr[11:2]] = s_wdata;
      end
    end
  end

  // compares every transfer and watches the protocol
  always @(posedge clk) begin
    if (!arst_n) begin
      held_ar <= 1'b0;
      held_aw <= 1'b0;
      held_w  <= 1'b0;
      if (arvalid || awvalid || wvalid || rready || bready || halted || error) begin
        n_errors++;
        $display("an output was high while reset was held");
      end
    end else begin
      if (held_ar && (!arvalid || araddr !== held_araddr)) begin
        n_errors++;
        $display("read address dropped or changed before its transfer");
      end
      if (held_aw && (!awvalid || awaddr !== held_awaddr)) begin
        n_errors++;
        $display("write address dropped or changed before its transfer");
      end
      if (held_w && (!wvalid || wdata !== held_wdata)) begin
        n_errors++;
        $display("write data dropped or changed before its transfer");
      end
      held_ar     <= arvalid && !arready;
      held_aw     <= awvalid && !awready;
      held_w      <= wvalid && !wready;
      held_araddr <= araddr;
      held_awaddr <= awaddr;
      held_wdata  <= wdata;
      if ((arvalid || rready) && (awvalid || wvalid || bready)) begin
        n_errors++;
        $display("a read and a write transaction were open at once");
      end
      if (halted && (arvalid || awvalid || wvalid)) begin
        n_errors++;
        $display("a valid was raised after the core halted");
      end
      if (arvalid && arready) begin
        if (exp_read.size() == 0) begin
          n_errors++;
          $display("read at %h that the model does not expect", araddr);
        end else begin
          check_fetch(araddr, exp_read.pop_front());
        end
      end
      if (awvalid && awready) mon_awaddr = awaddr;
      if (wvalid && wready) mon_wdata = wdata;
      if (bvalid && bready) begin
        if (exp_st_addr.size() == 0) begin
          n_errors++;
          $display("store at %h that the model does not expect", mon_awaddr);
        end else begin
          check_store(mon_awaddr, mon_wdata, exp_st_addr.pop_front(), exp_st_data.pop_front());
        end
      end
    end
  end

  initial begin
    wait (wd_armed);
    #(wd_limit);
    $display("timeout, the core did not halt in time");
    $display("tests failed");
    $finish;
  end

  initial begin
    int seed_val;
    clk      = 1'b0;
    arst_n   = 1'b0;
    arready  = 1'b0;
    rdata    = '0;
    rresp    = 2'b00;
    rvalid   = 1'b0;
    awready  = 1'b0;
    wready   = 1'b0;
    bresp    = 2'b00;
    bvalid   = 1'b0;
    n_checks = 0;
    n_errors = 0;
    bad_read = -1;
    wd_armed = 1'b0;
    seed_val = $urandom(32'h9da6_cf38);
    // 56 instructions over three runs plus reset and idle time per run
    wd_limit = (56 * 5 * 10 + 3 * 20) * 40;
    wd_armed = 1'b1;
    load_main_program();
    run_test(-1);
    // fault on the fetch of the lw
    load_main_program();
    run_test(10);
    load_illegal_program();
    run_test(-1);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- rv_core_top.f
rv_core_pkg.sv
core_fsm.sv
pc_counter.sv
inst_decoder.sv
reg_file.sv
exec_unit.sv
rv_core_top.sv
tb_rv_core.sv
